//--- include/adc_rx_config.svh
// widths and reset values for the ADC receive core; FIFO depth must stay a power of two
`ifndef ADC_RX_CONFIG_SVH
`define ADC_RX_CONFIG_SVH

// bits per ADC sample, one bit slot per ADC_CLK in a frame
`define ADC_RX_SAMPLE_BITS 14

// output FIFO depth in 32-bit words
`define ADC_RX_FIFO_DEPTH 16

// register reset values
`define ADC_RX_MODE_RESET  3'b000 // single, ext trigger, start with sync
`define ADC_RX_COUNT_RESET 24'd0  // 0 = record until reset
`define ADC_RX_SKIP_RESET  8'd1   // keep every sample
`define ADC_RX_DELAY_RESET 8'd0

// lost counter stops here
`define ADC_RX_LOST_MAX 8'hff

`endif

//--- src/adc_rx_pkg.sv
// data-path types; the output word layout only adds up to 32 bits for 14-bit samples
`include "adc_rx_config.svh"

package adc_rx_pkg;

    // one captured sample with the sync level seen at frame end
    typedef struct packed {
        logic                            sync;
        logic [`ADC_RX_SAMPLE_BITS-1:0]  code;
    } adc_sample_t;

    // output word, MSB first
    typedef struct packed {
        logic                            header;
        logic [1:0]                      id;
        logic                            sync;    // sync of earlier sample in paired mode
        logic [`ADC_RX_SAMPLE_BITS-1:0]  code_hi; // earlier sample, zero in single mode
        logic [`ADC_RX_SAMPLE_BITS-1:0]  code_lo; // later sample
    } adc_word_t;

    // sample gate states
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_SYNC = 2'd1, // armed, waiting for sync rising edge
        RECORD    = 2'd2,
        DONE      = 2'd3
    } gate_state_e;

endpackage

//--- src/adc_rx_reg_pkg.sv
// register map types; addresses not listed here are ignored on write and read as zero
package adc_rx_reg_pkg;

    // byte register addresses
    typedef enum logic [3:0] {
        RESET   = 4'd0,  // write: soft reset
        START   = 4'd1,  // write: start, read: done
        MODE    = 4'd2,
        CNT_HI  = 4'd3,
        CNT_MID = 4'd4,
        CNT_LO  = 4'd5,
        SKIP    = 4'd6,
        DELAY   = 4'd7,
        LOST    = 4'd15  // read only
    } reg_addr_e;

    // configuration seen by the data path
    typedef struct packed {
        logic        start_with_sync;
        logic        ext_trig_en;  // stored only
        logic        single_data;
        logic [23:0] count;        // 0 means no limit
        logic [7:0]  skip;
        logic [7:0]  delay;
    } rx_cfg_t;

    // MODE register bit positions
    localparam int MODE_SYNC_BIT   = 0;
    localparam int MODE_TRIG_BIT   = 1;
    localparam int MODE_SINGLE_BIT = 2;

endpackage

//--- src/adc_frame_deser.sv
// assumes fco rises together with the MSB on adc_in; runs free without fco
`timescale 1ns/100ps
`include "adc_rx_config.svh"

module adc_frame_deser (
    input  logic                   ADC_CLK,
    input  logic                   RST,
    input  logic                   adc_in,
    input  logic                   fco,
    output logic                   sample_stb,
    output adc_rx_pkg::adc_sample_t sample,
    input  logic                   sync_in
);

    localparam int BITS = `ADC_RX_SAMPLE_BITS;

    logic            in_buf;  // input register
    logic [BITS-1:0] shifter;
    logic            fco_q;
    logic            fco_q2;
    logic [3:0]      slot;
    logic            fco_rise;
    logic            last_slot;

    assign fco_rise  = fco_q & ~fco_q2;
    assign last_slot = (slot == 4'(BITS - 1));

    // data path, no reset
    always_ff @(posedge ADC_CLK) begin
        in_buf  <= adc_in;
        shifter <= {shifter[BITS-2:0], in_buf}; // MSB first
        if (last_slot) begin
            sample.code <= shifter;
            sample.sync <= sync_in;
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            fco_q      <= 1'b0;
            fco_q2     <= 1'b0;
            slot       <= '0;
            sample_stb <= 1'b0;
        end else begin
            fco_q  <= fco;
            fco_q2 <= fco_q;
            if (fco_rise || last_slot)
                slot <= '0; // realign on frame edge
            else
                slot <= slot + 4'd1;
            sample_stb <= last_slot;
        end
    end

endmodule

//--- src/adc_sample_gate.sv
// start restarts a recording from any state; skip of 0 behaves like 256
`timescale 1ns/100ps

module adc_sample_gate (
    input  logic                        ADC_CLK,
    input  logic                        RST,
    input  logic                        soft_rst,
    input  logic                        start,
    input  logic                        sync_in,
    input  adc_rx_reg_pkg::rx_cfg_t     cfg,
    input  logic                        sample_stb,
    input  adc_rx_pkg::adc_sample_t     sample,
    output logic                        keep_stb,
    output adc_rx_pkg::adc_sample_t     keep_sample,
    output logic                        done
);

    adc_rx_pkg::gate_state_e state;

    logic        sync_q;
    logic        sync_rise;
    logic [7:0]  phase;     // position inside the skip period
    logic [7:0]  skip_last;
    logic        selected;
    logic [23:0] rec_cnt;
    logic [23:0] rec_cnt_nxt;
    logic        last_one;

    assign sync_rise   = sync_in & ~sync_q;
    assign skip_last   = cfg.skip - 8'd1;
    assign selected    = sample_stb && (phase == cfg.delay);
    assign rec_cnt_nxt = rec_cnt + 24'd1;
    assign last_one    = (cfg.count != 24'd0) && (rec_cnt_nxt == cfg.count);

    // kept samples go out on the strobe cycle
    assign keep_stb    = (state == adc_rx_pkg::RECORD) && selected;
    assign keep_sample = sample;
    assign done        = (state == adc_rx_pkg::DONE);

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst) begin
            sync_q <= 1'b0;
            phase  <= '0;
        end else begin
            sync_q <= sync_in;
            if (sync_rise)
                phase <= '0; // sync realigns decimation
            else if (sample_stb)
                phase <= (phase == skip_last) ? 8'd0 : phase + 8'd1;
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst) begin
            state   <= adc_rx_pkg::IDLE;
            rec_cnt <= '0;
        end else if (start) begin
            rec_cnt <= '0;
            state   <= cfg.start_with_sync ? adc_rx_pkg::WAIT_SYNC : adc_rx_pkg::RECORD;
        end else begin
            case (state)
                adc_rx_pkg::WAIT_SYNC: begin
                    if (sync_rise)
                        state <= adc_rx_pkg::RECORD;
                end
                adc_rx_pkg::RECORD: begin
                    if (selected) begin
                        rec_cnt <= rec_cnt_nxt;
                        if (last_one)
                            state <= adc_rx_pkg::DONE;
                    end
                end
                default: begin
                    state <= state; // IDLE and DONE wait for start
                end
            endcase
        end
    end

endmodule

//--- src/adc_word_packer.sv
// paired mode drops an odd last sample; a start clears the pending half
`timescale 1ns/100ps

module adc_word_packer #(
    parameter logic [1:0] adc_id    = 2'd0,
    parameter logic [0:0] header_id = 1'b0
) (
    input  logic                        ADC_CLK,
    input  logic                        RST,
    input  logic                        soft_rst,
    input  logic                        start,
    input  adc_rx_reg_pkg::rx_cfg_t     cfg,
    input  logic                        keep_stb,
    input  adc_rx_pkg::adc_sample_t     keep_sample,
    output logic                        word_stb,
    output adc_rx_pkg::adc_word_t       word
);

    adc_rx_pkg::adc_sample_t prev;  // first half of a pair
    logic                    pair_phase;
    logic                    emit;

    // single: every sample, paired: every second one
    assign emit = keep_stb && (cfg.single_data || pair_phase);

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst || start) begin
            pair_phase <= 1'b0;
            word_stb   <= 1'b0;
        end else begin
            if (keep_stb && !cfg.single_data)
                pair_phase <= ~pair_phase;
            word_stb <= emit;
        end
    end

    always_ff @(posedge ADC_CLK) begin
        if (keep_stb)
            prev <= keep_sample;
        if (emit) begin
            word.header  <= header_id;
            word.id      <= adc_id;
            word.code_lo <= keep_sample.code;
            if (cfg.single_data) begin
                word.sync    <= keep_sample.sync;
                word.code_hi <= '0;
            end else begin
                word.sync    <= prev.sync; // flag of earlier sample
                word.code_hi <= prev.code;
            end
        end
    end

endmodule

//--- src/adc_rx_fifo.sv
// words arriving while full are dropped and counted; no write while full even if read
`timescale 1ns/100ps
`include "adc_rx_config.svh"

module adc_rx_fifo (
    input  logic                  ADC_CLK,
    input  logic                  RST,
    input  logic                  soft_rst,
    input  logic                  word_stb,
    input  adc_rx_pkg::adc_word_t word,
    output logic                  out_valid,
    input  logic                  out_ready,
    output adc_rx_pkg::adc_word_t out_data,
    output logic [7:0]            lost_cnt
);

    localparam int DEPTH = `ADC_RX_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    adc_rx_pkg::adc_word_t mem [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   used;  // occupancy
    logic          full;
    logic          wr_en;
    logic          rd_en;

    assign full      = (used == (AW+1)'(DEPTH));
    assign wr_en     = word_stb && !full;
    assign rd_en     = out_valid && out_ready;
    assign out_valid = (used != '0);
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge ADC_CLK) begin
        if (wr_en)
            mem[wr_ptr] <= word;
    end

    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;
            endcase
        end
    end

    // saturating loss counter
    always_ff @(posedge ADC_CLK) begin
        if (RST || soft_rst)
            lost_cnt <= '0;
        else if (word_stb && full && lost_cnt != `ADC_RX_LOST_MAX)
            lost_cnt <= lost_cnt + 8'd1;
    end

endmodule

//--- src/adc_rx_regs.sv
// start and soft reset are strobes on the write cycle; this block ignores soft reset
`timescale 1ns/100ps
`include "adc_rx_config.svh"

module adc_rx_regs (
    input  logic                      ADC_CLK,
    input  logic                      RST,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  adc_rx_reg_pkg::reg_addr_e reg_addr,
    input  logic [7:0]                reg_wdata,
    output logic [7:0]                reg_rdata,
    output adc_rx_reg_pkg::rx_cfg_t   cfg,
    output logic                      start,
    output logic                      soft_rst,
    input  logic                      done,
    input  logic [7:0]                lost_cnt
);

    logic [2:0] mode_bits;

    assign start    = reg_wr && (reg_addr == adc_rx_reg_pkg::START);
    assign soft_rst = reg_wr && (reg_addr == adc_rx_reg_pkg::RESET);

    assign mode_bits = {cfg.single_data, cfg.ext_trig_en, cfg.start_with_sync};

    always_ff @(posedge ADC_CLK) begin
        if (RST) begin
            {cfg.single_data, cfg.ext_trig_en, cfg.start_with_sync} <= `ADC_RX_MODE_RESET;
            cfg.count <= `ADC_RX_COUNT_RESET;
            cfg.skip  <= `ADC_RX_SKIP_RESET;
            cfg.delay <= `ADC_RX_DELAY_RESET;
        end else if (reg_wr) begin
            case (reg_addr)
                adc_rx_reg_pkg::MODE: begin
                    cfg.start_with_sync <= reg_wdata[adc_rx_reg_pkg::MODE_SYNC_BIT];
                    cfg.ext_trig_en     <= reg_wdata[adc_rx_reg_pkg::MODE_TRIG_BIT];
                    cfg.single_data     <= reg_wdata[adc_rx_reg_pkg::MODE_SINGLE_BIT];
                end
                adc_rx_reg_pkg::CNT_HI:  cfg.count[23:16] <= reg_wdata;
                adc_rx_reg_pkg::CNT_MID: cfg.count[15:8]  <= reg_wdata;
                adc_rx_reg_pkg::CNT_LO:  cfg.count[7:0]   <= reg_wdata;
                adc_rx_reg_pkg::SKIP:    cfg.skip         <= reg_wdata;
                adc_rx_reg_pkg::DELAY:   cfg.delay        <= reg_wdata;
                default: begin
                    cfg <= cfg; // strobes and read-only
                end
            endcase
        end
    end

    // readback one cycle after reg_rd
    always_ff @(posedge ADC_CLK) begin
        if (reg_rd) begin
            case (reg_addr)
                adc_rx_reg_pkg::START:   reg_rdata <= {7'd0, done};
                adc_rx_reg_pkg::MODE:    reg_rdata <= {5'd0, mode_bits};
                adc_rx_reg_pkg::CNT_HI:  reg_rdata <= cfg.count[23:16];
                adc_rx_reg_pkg::CNT_MID: reg_rdata <= cfg.count[15:8];
                adc_rx_reg_pkg::CNT_LO:  reg_rdata <= cfg.count[7:0];
                adc_rx_reg_pkg::SKIP:    reg_rdata <= cfg.skip;
                adc_rx_reg_pkg::DELAY:   reg_rdata <= cfg.delay;
                adc_rx_reg_pkg::LOST:    reg_rdata <= lost_cnt;
                default:                 reg_rdata <= 8'd0;
            endcase
        end
    end

endmodule

//--- src/adc_rx_core.sv
// one ADC channel on a single ADC_CLK domain; data path never stalls, overflow is counted
`timescale 1ns/100ps

module adc_rx_core #(
    parameter logic [1:0] adc_id    = 2'd0,
    parameter logic [0:0] header_id = 1'b0
) (
    input  logic                      ADC_CLK,
    input  logic                      RST,
    input  logic                      adc_in,
    input  logic                      fco,
    input  logic                      adc_sync,
    input  logic                      reg_wr,
    input  logic                      reg_rd,
    input  adc_rx_reg_pkg::reg_addr_e reg_addr,
    input  logic [7:0]                reg_wdata,
    output logic [7:0]                reg_rdata,
    output logic                      out_valid,
    input  logic                      out_ready,
    output adc_rx_pkg::adc_word_t     out_data,
    output logic                      lost_error
);

    adc_rx_reg_pkg::rx_cfg_t  cfg;
    adc_rx_pkg::adc_sample_t  sample;
    adc_rx_pkg::adc_sample_t  keep_sample;
    adc_rx_pkg::adc_word_t    word;

    logic       start;
    logic       soft_rst;
    logic       done;
    logic [7:0] lost_cnt;
    logic       sample_stb;
    logic       keep_stb;
    logic       word_stb;

    assign lost_error = (lost_cnt != 8'd0);

    adc_rx_regs regs_i (
        .ADC_CLK, .RST, .reg_wr, .reg_rd, .reg_addr, .reg_wdata, .reg_rdata,
        .cfg, .start, .soft_rst, .done, .lost_cnt
    );

    adc_frame_deser deser_i (
        .ADC_CLK, .RST, .adc_in, .fco, .sample_stb, .sample, .sync_in(adc_sync)
    );

    adc_sample_gate gate_i (
        .ADC_CLK, .RST, .soft_rst, .start, .sync_in(adc_sync), .cfg,
        .sample_stb, .sample, .keep_stb, .keep_sample, .done
    );

    adc_word_packer #(.adc_id(adc_id), .header_id(header_id)) packer_i (
        .ADC_CLK, .RST, .soft_rst, .start, .cfg, .keep_stb, .keep_sample,
        .word_stb, .word
    );

    adc_rx_fifo fifo_i (
        .ADC_CLK, .RST, .soft_rst, .word_stb, .word,
        .out_valid, .out_ready, .out_data, .lost_cnt
    );

endmodule

//--- tb/adc_rx_properties.sv
// bound into adc_rx_core; soft reset may clear the FIFO and the loss counter at any time
`timescale 1ns/100ps

module adc_rx_properties (
    input logic                  ADC_CLK,
    input logic                  RST,
    input logic                  soft_rst,
    input logic                  out_valid,
    input logic                  out_ready,
    input adc_rx_pkg::adc_word_t out_data,
    input logic [7:0]            lost_cnt
);

    // stalled word holds still and stays offered
    a_stall_stable: assert property (@(posedge ADC_CLK) disable iff (RST)
        (out_valid && !out_ready && !soft_rst) |=> (out_valid && $stable(out_data)))
        else $error("out_data changed or out_valid dropped while stalled");

    a_reset_valid: assert property (@(posedge ADC_CLK)
        RST |=> !out_valid)
        else $error("out_valid high after reset");

    // saturates, never wraps to 0
    a_lost_sat: assert property (@(posedge ADC_CLK) disable iff (RST)
        (lost_cnt == 8'hff && !soft_rst) |=> (lost_cnt == 8'hff))
        else $error("lost_cnt wrapped past 255");

endmodule

//--- include/adc_rx_tb_config.svh
// testbench limits; frame budget is summed over all tests and must cover the longest run
`ifndef ADC_RX_TB_CONFIG_SVH
`define ADC_RX_TB_CONFIG_SVH

// frames each test may use: regs, single, paired, decimate, sync start, overflow
`define ADC_RX_TB_FRAMES (20 + 30 + 20 + 25 + 20 + 290)

// frames in the stimulus tables
`define ADC_RX_TB_MAX_FRAMES 2048

`endif

//--- tb/adc_rx_tb.sv
// one channel with id 2 and header 1; register writes that matter are aligned to bit slot 5
`timescale 1ns/100ps
`include "adc_rx_config.svh"
`include "adc_rx_tb_config.svh"

module adc_rx_tb;

    localparam int SB    = `ADC_RX_SAMPLE_BITS;
    localparam int LIMIT = `ADC_RX_TB_FRAMES * 14 * 3 / 2;

    logic ADC_CLK = 1'b0;
    logic RST = 1'b1;
    logic adc_in = 1'b0;
    logic fco = 1'b0;
    logic adc_sync = 1'b0;
    logic reg_wr = 1'b0;
    logic reg_rd = 1'b0;
    adc_rx_reg_pkg::reg_addr_e reg_addr = adc_rx_reg_pkg::RESET;
    logic [7:0] reg_wdata = 8'd0;
    logic [7:0] reg_rdata;
    logic out_valid;
    logic out_ready = 1'b1;
    adc_rx_pkg::adc_word_t out_data;
    logic lost_error;

    logic [SB-1:0] codes [`ADC_RX_TB_MAX_FRAMES];
    bit sync_plan [`ADC_RX_TB_MAX_FRAMES];
    adc_rx_pkg::adc_word_t exp_q[$];
    adc_rx_pkg::adc_word_t got[$];
    logic [31:0] rng = 32'h6e1d_c89e;
    int fr = 0;       // frame being sent
    int bitc = 0;     // bit slot being sent
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;

    adc_rx_core #(.adc_id(2'd2), .header_id(1'b1)) adc_rx_core_i (.*);

    bind adc_rx_core adc_rx_properties props_i (
        .ADC_CLK, .RST, .soft_rst, .out_valid, .out_ready, .out_data, .lost_cnt
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    initial begin
        forever #20 ADC_CLK = ~ADC_CLK;
    end

    // serializer, MSB first, fco with the MSB, sync changes at slot 3
    always @(posedge ADC_CLK) begin
        adc_in <= codes[fr][SB - 1 - bitc];
        fco    <= (bitc == 0);
        if (bitc == 3)
            adc_sync <= sync_plan[fr];
        if (bitc == SB - 1) begin
            bitc <= 0;
            fr   <= fr + 1;
        end else begin
            bitc <= bitc + 1;
        end
    end

    always @(posedge ADC_CLK) begin
        if (out_valid && out_ready)
            got.push_back(out_data);
    end

    always @(posedge ADC_CLK) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input adc_rx_pkg::adc_word_t exp,
                              input adc_rx_pkg::adc_word_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("[FAIL] %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic write_reg(input adc_rx_reg_pkg::reg_addr_e a, input logic [7:0] d);
        @(posedge ADC_CLK);
        reg_wr    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge ADC_CLK);
        reg_wr <= 1'b0;
    endtask

    // returns the frame whose sample is the first one after the write
    task automatic write_aligned(input adc_rx_reg_pkg::reg_addr_e a, output int frame);
        do @(posedge ADC_CLK); while (bitc != 5);
        frame     = fr;
        reg_wr    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= 8'd0;
        @(posedge ADC_CLK);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input adc_rx_reg_pkg::reg_addr_e a, output logic [7:0] d);
        @(posedge ADC_CLK);
        reg_rd   <= 1'b1;
        reg_addr <= a;
        @(posedge ADC_CLK);
        reg_rd <= 1'b0;
        @(posedge ADC_CLK);
        d = reg_rdata;
    endtask

    // frame level model of decimation, record count, sync start and packing
    task automatic build_expected(input int p0, input int g, input bit ws, input int sk,
                                  input int dl, input int cnt, input bit single,
                                  input int last_f);
        int phase;
        int kept;
        bit rec;
        bit armed;
        bit rise;
        bit have_prev;
        logic [SB-1:0] pcode;
        logic psync;
        adc_rx_pkg::adc_word_t w;
        phase = 0;
        kept = 0;
        rec = 0;
        armed = ws;
        have_prev = 0;
        exp_q.delete();
        for (int f = p0; f <= last_f; f++) begin
            rise = (f > p0) && sync_plan[f] && !sync_plan[f-1];
            if (rise)
                phase = 0;
            if (f == g && !ws)
                rec = 1;
            if (armed && f > g && rise) begin
                rec = 1;
                armed = 0;
            end
            if (rec && phase == dl) begin
                kept++;
                w.header = 1'b1;
                w.id = 2'd2;
                w.code_lo = codes[f];
                if (single) begin
                    w.sync = sync_plan[f];
                    w.code_hi = '0;
                    exp_q.push_back(w);
                end else if (have_prev) begin
                    w.sync = psync;
                    w.code_hi = pcode;
                    exp_q.push_back(w);
                    have_prev = 0;
                end else begin
                    pcode = codes[f];
                    psync = sync_plan[f];
                    have_prev = 1;
                end
                if (cnt != 0 && kept == cnt)
                    rec = 0;
            end
            phase = (phase >= sk - 1) ? 0 : phase + 1;
        end
    endtask

    task automatic compare_words(input string name);
        check_byte({name, " word count"}, 8'(exp_q.size()), 8'(got.size()));
        for (int i = 0; i < exp_q.size() && i < got.size(); i++)
            check_word($sformatf("%s word %0d", name, i), exp_q[i], got[i]);
    endtask

    task automatic report_test(input string name, input int errs0);
        tests++;
        $display("test %s: %s", name, (errors == errs0) ? "ok" : "errors");
    endtask

    task automatic run_capture(input string name, input logic [7:0] mode, input int cnt,
                               input int sk, input int dl, input int sync_rel,
                               input int sync_len);
        int errs0;
        int p0;
        int g;
        logic [7:0] d;
        errs0 = errors;
        write_reg(adc_rx_reg_pkg::MODE, mode);
        write_reg(adc_rx_reg_pkg::CNT_HI, 8'(cnt >> 16));
        write_reg(adc_rx_reg_pkg::CNT_MID, 8'(cnt >> 8));
        write_reg(adc_rx_reg_pkg::CNT_LO, 8'(cnt));
        write_reg(adc_rx_reg_pkg::SKIP, 8'(sk));
        write_reg(adc_rx_reg_pkg::DELAY, 8'(dl));
        write_aligned(adc_rx_reg_pkg::RESET, p0);
        got.delete();
        write_aligned(adc_rx_reg_pkg::START, g);
        for (int i = 0; i < sync_len; i++)
            sync_plan[g + sync_rel + i] = 1'b1;
        build_expected(p0, g, mode[0], sk, dl, cnt, mode[2], g + 60);
        if (mode[0]) begin
            while (fr < g + sync_rel)
                @(posedge ADC_CLK);
            check_byte({name, " idle before sync"}, 8'd0, 8'(got.size()));
        end
        while (got.size() < exp_q.size())
            @(posedge ADC_CLK);
        repeat (3 * SB) @(posedge ADC_CLK); // catch extra words
        compare_words(name);
        if (cnt != 0) begin
            read_reg(adc_rx_reg_pkg::START, d);
            check_bit({name, " done"}, 1'b1, d[0]);
        end
        report_test(name, errs0);
    endtask

    initial begin
        logic [7:0] vals [6];
        logic [7:0] d;
        adc_rx_reg_pkg::reg_addr_e addrs [6];
        int errs0;
        int g;
        for (int i = 0; i < `ADC_RX_TB_MAX_FRAMES; i++) begin
            rng = xorshift(rng);
            codes[i] = rng[SB-1:0];
            sync_plan[i] = 1'b0;
        end
        repeat (3) @(posedge ADC_CLK);
        RST <= 1'b0;
        repeat (2 * SB) @(posedge ADC_CLK);

        // register readback, also after a soft reset
        errs0 = errors;
        addrs = '{adc_rx_reg_pkg::MODE, adc_rx_reg_pkg::CNT_HI, adc_rx_reg_pkg::CNT_MID,
                  adc_rx_reg_pkg::CNT_LO, adc_rx_reg_pkg::SKIP, adc_rx_reg_pkg::DELAY};
        for (int i = 0; i < 6; i++) begin
            rng = xorshift(rng);
            vals[i] = rng[7:0];
            if (i == 0)
                vals[i] = vals[i] | 8'hf8; // unused mode bits written high
            write_reg(addrs[i], vals[i]);
        end
        vals[0] = vals[0] & 8'h07; // three mode flags only
        write_reg(adc_rx_reg_pkg::RESET, 8'd0);
        for (int i = 0; i < 6; i++) begin
            read_reg(addrs[i], d);
            check_byte($sformatf("regs addr %0d", addrs[i]), vals[i], d);
        end
        report_test("regs", errs0);

        run_capture("single", 8'h04, 20, 1, 0, 0, 0);
        run_capture("paired", 8'h00, 9, 1, 0, 0, 0);
        run_capture("decimate", 8'h04, 4, 4, 2, 3, 3);
        run_capture("sync start", 8'h05, 5, 1, 0, 4, 2);

        // overflow with the output stalled
        errs0 = errors;
        write_reg(adc_rx_reg_pkg::MODE, 8'h04);
        write_reg(adc_rx_reg_pkg::CNT_HI, 8'd0);
        write_reg(adc_rx_reg_pkg::CNT_MID, 8'd0);
        write_reg(adc_rx_reg_pkg::CNT_LO, 8'd0);
        write_reg(adc_rx_reg_pkg::SKIP, 8'd1);
        write_reg(adc_rx_reg_pkg::DELAY, 8'd0);
        write_aligned(adc_rx_reg_pkg::RESET, g);
        got.delete();
        out_ready <= 1'b0;
        write_aligned(adc_rx_reg_pkg::START, g);
        build_expected(g - 1, g, 1'b0, 1, 0, 0, 1'b1, g + `ADC_RX_FIFO_DEPTH - 1);
        while (fr < g + `ADC_RX_FIFO_DEPTH + 255 + 4)
            @(posedge ADC_CLK);
        write_reg(adc_rx_reg_pkg::MODE, 8'h05); // park the gate in WAIT_SYNC
        write_reg(adc_rx_reg_pkg::START, 8'd0);
        repeat (2 * SB) @(posedge ADC_CLK);
        read_reg(adc_rx_reg_pkg::LOST, d);
        check_byte("overflow lost count", 8'hff, d);
        check_bit("overflow lost_error", 1'b1, lost_error);
        out_ready <= 1'b1;
        while (got.size() < exp_q.size())
            @(posedge ADC_CLK);
        repeat (3 * SB) @(posedge ADC_CLK);
        compare_words("overflow");
        write_reg(adc_rx_reg_pkg::RESET, 8'd0);
        @(posedge ADC_CLK);
        check_bit("overflow lost_error after soft reset", 1'b0, lost_error);
        report_test("overflow", errs0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- adc_rx.f
+incdir+include
src/adc_rx_pkg.sv
src/adc_rx_reg_pkg.sv
src/adc_frame_deser.sv
src/adc_sample_gate.sv
src/adc_word_packer.sv
src/adc_rx_fifo.sv
src/adc_rx_regs.sv
src/adc_rx_core.sv
tb/adc_rx_properties.sv
tb/adc_rx_tb.sv
